// ==== touch_pkg.sv ====
package touch_pkg;

	// Converter channels in conversion order
	typedef enum logic [1:0] {
		AXIS_X = 2'd0,
		AXIS_Y = 2'd1,
		AXIS_Z = 2'd2
	} touch_axis_e;

	// Channel select codes, command bits 6 to 4
	localparam logic [2:0] CH_X = 3'b101;
	localparam logic [2:0] CH_Y = 3'b001;
	localparam logic [2:0] CH_Z = 3'b011;

	// Serial clocks per frame, csb stays low for all of them
	localparam int FRAME_CLOCKS = 24;

	// Command length, sent MSB first on rises 1 to 8
	localparam int CMD_BITS = 8;

	// Rising edge that carries the result MSB
	localparam int SAMPLE_FIRST = 10;

	// Result width
	localparam int SAMPLE_BITS = 12;

	// X trim window
	localparam logic [11:0] X_ADJ_MIN      = 12'h096;
	localparam logic [11:0] X_POST_ADJ_MAX = 12'hF6E;

	// Y trim window
	localparam logic [11:0] Y_ADJ_MIN      = 12'h12C;
	localparam logic [11:0] Y_POST_ADJ_MAX = 12'hED8;

endpackage

// ==== touch_frame_if.sv ====
`timescale 1ns/100ps

interface touch_frame_if;

	// One-cycle request, only while busy is low
	logic        start;
	// Command byte, taken on the start cycle
	logic [7:0]  cmd;
	// One-cycle pulse when csb goes back high
	logic        done;
	// Result of the last frame, held until the next done
	logic [11:0] sample;
	// Port is in a frame or in the gap after it
	logic        busy;

	modport seq (
		output start,
		output cmd,
		input  done,
		input  sample,
		input  busy
	);

	modport port (
		input  start,
		input  cmd,
		output done,
		output sample,
		output busy
	);

endinterface

// ==== touch_clk_gen.sv ====
`timescale 1ns/100ps

module touch_clk_gen #(
	parameter int CLK_DIV = 25
) (
	input  logic cclk,
	input  logic rstb,
	input  logic run,
	output logic touch_clk,
	output logic sclk_rise,
	output logic sclk_fall
);

	localparam int DIV_W = $clog2(CLK_DIV + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_DIV - 1);

	logic [DIV_W-1:0] div_cnt;
	logic             tick;

	// Last cycle of a half period, touch_clk flips on the edge that ends it
	assign tick      = run && (div_cnt == DIV_LAST);
	assign sclk_rise = tick && !touch_clk;
	assign sclk_fall = tick && touch_clk;

	always_ff @(posedge cclk) begin
		if (rstb || !run) begin
			// Stopped clock parks low so the next frame starts with a clean half period
			div_cnt   <= '0;
			touch_clk <= 1'b0;
		end else if (tick) begin
			div_cnt   <= '0;
			touch_clk <= ~touch_clk;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	a_one_strobe: assert property (@(posedge cclk) disable iff (rstb)
		!(sclk_rise && sclk_fall));

endmodule

// ==== touch_spi_port.sv ====
`timescale 1ns/100ps

module touch_spi_port #(
	parameter int CLK_DIV = 25
) (
	input  logic          cclk,
	input  logic          rstb,
	touch_frame_if.port   frame,
	output logic          touch_clk,
	output logic          touch_csb,
	output logic          data_out,
	input  logic          data_in
);

	import touch_pkg::*;

	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		FRAME = 2'd1,
		GAP   = 2'd2
	} port_state_e;

	localparam int GAP_W = $clog2(CLK_DIV + 1);
	// Gap state plus the idle cycle give CLK_DIV cycles of csb high
	localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(CLK_DIV - 2);

	// Rise counts before the sampled rises 10 to 21, and the frame end
	localparam logic [4:0] SAMPLE_LO = 5'(SAMPLE_FIRST - 1);
	localparam logic [4:0] SAMPLE_HI = 5'(SAMPLE_FIRST + SAMPLE_BITS - 2);
	localparam logic [4:0] LAST_EDGE = 5'(FRAME_CLOCKS);

	port_state_e            state;
	logic [GAP_W-1:0]       gap_cnt;
	logic [4:0]             edge_cnt;
	logic [CMD_BITS-1:0]    cmd_sr;
	logic [SAMPLE_BITS-1:0] shift_in;
	logic                   run;
	logic                   sclk_rise;
	logic                   sclk_fall;
	logic                   sample_en;
	logic                   frame_end;

	assign run        = (state == FRAME);
	assign frame.busy = (state != IDLE);

	// Command MSB sits on the line from csb fall, zeros fill in behind it
	assign data_out = cmd_sr[CMD_BITS-1];

	// edge_cnt holds the number of rises already seen
	assign sample_en = run && sclk_rise && (edge_cnt >= SAMPLE_LO) && (edge_cnt <= SAMPLE_HI);
	assign frame_end = run && sclk_fall && (edge_cnt == LAST_EDGE);

	touch_clk_gen #(
		.CLK_DIV (CLK_DIV)
	) u_clk_gen (
		.cclk      (cclk),
		.rstb      (rstb),
		.run       (run),
		.touch_clk (touch_clk),
		.sclk_rise (sclk_rise),
		.sclk_fall (sclk_fall)
	);

	always_ff @(posedge cclk) begin
		if (rstb) begin
			// Leave reset through a gap so the first start waits CLK_DIV cycles
			state      <= GAP;
			gap_cnt    <= '0;
			edge_cnt   <= '0;
			cmd_sr     <= '0;
			touch_csb  <= 1'b1;
			frame.done <= 1'b0;
		end else begin
			frame.done <= 1'b0;
			case (state)
				IDLE: begin
					if (frame.start) begin
						state     <= FRAME;
						touch_csb <= 1'b0;
						cmd_sr    <= frame.cmd;
						edge_cnt  <= '0;
					end
				end
				FRAME: begin
					if (sclk_rise) begin
						edge_cnt <= edge_cnt + 1'b1;
					end
					if (sclk_fall) begin
						cmd_sr <= {cmd_sr[CMD_BITS-2:0], 1'b0};
					end
					// csb rises together with the last falling edge
					if (frame_end) begin
						state      <= GAP;
						touch_csb  <= 1'b1;
						frame.done <= 1'b1;
						gap_cnt    <= '0;
					end
				end
				GAP: begin
					if (gap_cnt == GAP_LAST) begin
						state <= IDLE;
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end
				default: state <= GAP;
			endcase
		end
	end

	// Result bits arrive MSB first
	always_ff @(posedge cclk) begin
		if (sample_en) begin
			shift_in <= {shift_in[SAMPLE_BITS-2:0], data_in};
		end
		if (frame_end) begin
			frame.sample <= shift_in;
		end
	end

	a_start_idle: assert property (@(posedge cclk) disable iff (rstb)
		frame.start |-> !frame.busy);

	a_clk_quiet: assert property (@(posedge cclk) disable iff (rstb)
		touch_csb && $past(touch_csb) |-> $stable(touch_clk));

endmodule

// ==== touch_sequencer.sv ====
`timescale 1ns/100ps

module touch_sequencer #(
	parameter int REPEATS = 16
) (
	input  logic                    cclk,
	input  logic                    rstb,
	touch_frame_if.seq              frame,
	output logic [11:0]             result,
	output touch_pkg::touch_axis_e  result_axis,
	output logic                    result_valid
);

	import touch_pkg::*;

	localparam int REP_W = $clog2(REPEATS + 1);
	localparam logic [REP_W-1:0] REP_LAST = REP_W'(REPEATS - 1);

	touch_axis_e      axis;
	touch_axis_e      axis_next;
	logic [REP_W-1:0] rep_cnt;
	logic [2:0]       ch_code;
	logic             last_frame;

	// Channel select for the axis being converted
	always_comb begin
		case (axis)
			AXIS_X:  ch_code = CH_X;
			AXIS_Y:  ch_code = CH_Y;
			default: ch_code = CH_Z;
		endcase
	end

	// X then Y then Z, then around again
	always_comb begin
		case (axis)
			AXIS_X:  axis_next = AXIS_Y;
			AXIS_Y:  axis_next = AXIS_Z;
			default: axis_next = AXIS_X;
		endcase
	end

	// Start bit, channel, then differential 12-bit mode with power bits low
	assign frame.cmd = {1'b1, ch_code, 4'b0000};

	// Port is idle for exactly one cycle between frames, so this is a single pulse
	assign frame.start = !frame.busy;

	// Earlier frames of a burst only let the panel settle
	assign last_frame = (rep_cnt == REP_LAST);

	always_ff @(posedge cclk) begin
		if (rstb) begin
			axis         <= AXIS_X;
			rep_cnt      <= '0;
			result_axis  <= AXIS_X;
			result_valid <= 1'b0;
		end else begin
			result_valid <= 1'b0;
			if (frame.done) begin
				if (last_frame) begin
					rep_cnt      <= '0;
					axis         <= axis_next;
					result_axis  <= axis;
					result_valid <= 1'b1;
				end else begin
					rep_cnt <= rep_cnt + 1'b1;
				end
			end
		end
	end

	// Burst result, overwritten by the next one
	always_ff @(posedge cclk) begin
		if (frame.done && last_frame) begin
			result <= frame.sample;
		end
	end

	a_axis_legal: assert property (@(posedge cclk) disable iff (rstb)
		result_axis inside {AXIS_X, AXIS_Y, AXIS_Z});

endmodule

// ==== touch_calibrate.sv ====
`timescale 1ns/100ps

module touch_calibrate (
	input  logic                    cclk,
	input  logic                    rstb,
	input  logic [11:0]             result,
	input  touch_pkg::touch_axis_e  result_axis,
	input  logic                    result_valid,
	output logic [11:0]             x,
	output logic [11:0]             y,
	output logic [11:0]             z,
	output logic                    xyz_update
);

	import touch_pkg::*;

	// Remove the panel offset and clip to the usable range
	function automatic logic [11:0] trim(
		input logic [11:0] raw,
		input logic [11:0] adj_min,
		input logic [11:0] post_max
	);
		logic [11:0] diff;
		diff = raw - adj_min;
		if (raw < adj_min) begin
			trim = 12'h000;
		end else if (diff > post_max) begin
			trim = post_max;
		end else begin
			trim = diff;
		end
	endfunction

	always_ff @(posedge cclk) begin
		if (rstb) begin
			x          <= 12'h000;
			y          <= 12'h000;
			z          <= 12'h000;
			xyz_update <= 1'b0;
		end else begin
			xyz_update <= result_valid;
			if (result_valid) begin
				case (result_axis)
					AXIS_X:  x <= trim(result, X_ADJ_MIN, X_POST_ADJ_MAX);
					AXIS_Y:  y <= trim(result, Y_ADJ_MIN, Y_POST_ADJ_MAX);
					// Pressure is used raw
					AXIS_Z:  z <= result;
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== touchpad_controller.sv ====
`timescale 1ns/100ps

module touchpad_controller #(
	parameter int CLK_DIV = 25,
	parameter int REPEATS = 16
) (
	input  logic        cclk,
	input  logic        rstb,
	input  logic        data_in,
	output logic        touch_clk,
	output logic        touch_csb,
	output logic        data_out,
	output logic [11:0] x,
	output logic [11:0] y,
	output logic [11:0] z,
	output logic        xyz_update
);

	import touch_pkg::*;

	logic [11:0] result;
	touch_axis_e result_axis;
	logic        result_valid;

	// Frame requests from the sequencer to the serial port
	touch_frame_if frame_bus ();

	touch_spi_port #(
		.CLK_DIV (CLK_DIV)
	) u_spi_port (
		.cclk      (cclk),
		.rstb      (rstb),
		.frame     (frame_bus.port),
		.touch_clk (touch_clk),
		.touch_csb (touch_csb),
		.data_out  (data_out),
		.data_in   (data_in)
	);

	touch_sequencer #(
		.REPEATS (REPEATS)
	) u_sequencer (
		.cclk         (cclk),
		.rstb         (rstb),
		.frame        (frame_bus.seq),
		.result       (result),
		.result_axis  (result_axis),
		.result_valid (result_valid)
	);

	touch_calibrate u_calibrate (
		.cclk         (cclk),
		.rstb         (rstb),
		.result       (result),
		.result_axis  (result_axis),
		.result_valid (result_valid),
		.x            (x),
		.y            (y),
		.z            (z),
		.xyz_update   (xyz_update)
	);

endmodule

// ==== touch_adc_model.sv ====
`timescale 1ns/100ps

module touch_adc_model #(
	parameter int REPEATS = 16,
	parameter int SEED    = 1
) (
	input  logic        cclk,
	input  logic        touch_clk,
	input  logic        touch_csb,
	input  logic        data_out,
	output logic        data_in,
	output logic [7:0]  cmd_seen,
	output logic [11:0] exp_x,
	output logic [11:0] exp_y,
	output logic [11:0] exp_z
);

	import touch_pkg::*;

	logic [11:0] pool [0:63];
	logic [11:0] reply;
	logic [7:0]  cmd_sr;
	logic        clk_q, csb_q;
	int          rises, falls, frame_n;

	function automatic touch_axis_e decode_channel(input logic [2:0] code);
		case (code)
			CH_X:    return AXIS_X;
			CH_Y:    return AXIS_Y;
			default: return AXIS_Z;
		endcase
	endfunction

	// Offset removal with a ceiling, worked out in signed arithmetic
	function automatic logic [11:0] calibrated(input logic [11:0] raw, input logic [11:0] lo,
			input logic [11:0] hi);
		int v;
		v = int'(raw) - int'(lo);
		if (v < 0)
			v = 0;
		if (v > int'(hi))
			v = int'(hi);
		return 12'(v);
	endfunction

	// Corner values per burst round, random otherwise
	function automatic logic [11:0] pick_raw(input touch_axis_e ax, input int round,
			input logic [11:0] rnd);
		logic [11:0] lo;
		lo = (ax == AXIS_X) ? X_ADJ_MIN : Y_ADJ_MIN;
		if (ax == AXIS_Z)
			return (round == 1) ? 12'h000 : (round == 2) ? 12'hFFF : rnd;
		case (round)
			0:       return 12'h000;
			1:       return lo;
			2:       return lo + 12'd1;
			3:       return 12'hFFF;
			default: return rnd;
		endcase
	endfunction

	initial begin
		void'($urandom(SEED));
		for (int i = 0; i < 64; i++)
			pool[i] = 12'($urandom);
		data_in = 1'b0;
		cmd_seen = 8'h00;
		exp_x = 12'h000;
		exp_y = 12'h000;
		exp_z = 12'h000;
		reply = 12'h000;
		cmd_sr = 8'h00;
		clk_q = 1'b0;
		csb_q = 1'b1;
		rises = 0;
		falls = 0;
		frame_n = 0;
	end

	// Edges are seen one half cycle after touch_clk moves
	always @(negedge cclk) begin : serve_frame
		logic [11:0] raw;
		touch_axis_e ax;
		clk_q <= touch_clk;
		csb_q <= touch_csb;
		if (touch_csb) begin
			rises <= 0;
			falls <= 0;
			data_in <= 1'b0;
			if (!csb_q)
				frame_n <= frame_n + 1;
		end else begin
			if (touch_clk && !clk_q) begin
				rises <= rises + 1;
				if (rises < CMD_BITS)
					cmd_sr <= {cmd_sr[CMD_BITS-2:0], data_out};
			end
			if (!touch_clk && clk_q) begin
				falls <= falls + 1;
				// Fall 9 puts the result MSB on the line
				if (falls == SAMPLE_FIRST - 2) begin
					ax = decode_channel(cmd_sr[6:4]);
					raw = pick_raw(ax, (frame_n / REPEATS) / 3, pool[frame_n % 64]);
					reply <= raw;
					data_in <= raw[SAMPLE_BITS-1];
					cmd_seen <= cmd_sr;
					case (ax)
						AXIS_X:  exp_x <= calibrated(raw, X_ADJ_MIN, X_POST_ADJ_MAX);
						AXIS_Y:  exp_y <= calibrated(raw, Y_ADJ_MIN, Y_POST_ADJ_MAX);
						default: exp_z <= raw;
					endcase
				end else if (falls >= SAMPLE_FIRST - 1 &&
						falls <= SAMPLE_FIRST + SAMPLE_BITS - 3) begin
					data_in <= reply[SAMPLE_FIRST + SAMPLE_BITS - 3 - falls];
				end else begin
					data_in <= 1'b0;
				end
			end
		end
	end

endmodule

// ==== tb_touchpad.sv ====
`timescale 1ns/100ps

module tb_touchpad;

	import touch_pkg::*;

	localparam int CLK_DIV    = 3;
	localparam int REPEATS    = 2;
	localparam int FRAMES     = 36;
	localparam int TIMEOUT_NS = FRAMES * (48 + 2) * CLK_DIV * 40 * 2;

	logic        cclk, rstb, data_in, touch_clk, touch_csb, data_out, xyz_update;
	logic [11:0] x, y, z, exp_x, exp_y, exp_z;
	logic [7:0]  cmd_seen;

	int          frame_idx = 0, update_cnt = 0, rise_cnt = 0, gap_cnt = 0, cycle_cnt = 0;
	logic        first_seen = 1'b0, clk_q = 1'b0, csb_q = 1'b1;
	logic [11:0] x_q = '0, y_q = '0, z_q = '0;

	touchpad_controller #(.CLK_DIV(CLK_DIV), .REPEATS(REPEATS)) UUT (
		.cclk(cclk), .rstb(rstb), .data_in(data_in), .touch_clk(touch_clk),
		.touch_csb(touch_csb), .data_out(data_out), .x(x), .y(y), .z(z),
		.xyz_update(xyz_update)
	);

	touch_adc_model #(.REPEATS(REPEATS), .SEED(1226)) u_adc (
		.cclk(cclk), .touch_clk(touch_clk), .touch_csb(touch_csb), .data_out(data_out),
		.data_in(data_in), .cmd_seen(cmd_seen), .exp_x(exp_x), .exp_y(exp_y), .exp_z(exp_z)
	);

	task automatic report_mismatch(input string name, input int expected, input int actual);
		$display("[FAIL] %0t ns %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic abort_run(input string what);
		$display("%s at %0t ns", what, $time);
		$display("Test failed");
		$fatal(1);
	endtask

	// Bursts go X, Y, Z and each holds REPEATS frames
	function automatic touch_axis_e axis_of_frame(input int n);
		return touch_axis_e'((n / REPEATS) % 3);
	endfunction

	function automatic logic [7:0] command_for(input int n);
		case (axis_of_frame(n))
			AXIS_X:  return {1'b1, 3'b101, 4'b0000};
			AXIS_Y:  return {1'b1, 3'b001, 4'b0000};
			default: return {1'b1, 3'b011, 4'b0000};
		endcase
	endfunction

	initial begin
		cclk = 1'b0;
		forever #20 cclk = ~cclk;
	end

	initial begin
		rstb = 1'b1;
		repeat (16) @(negedge cclk);
		rstb = 1'b0;
		wait (frame_idx == FRAMES);
		// Last update lands two cycles after the final done
		repeat (4) @(negedge cclk);
		if (update_cnt == FRAMES / REPEATS) begin
			$display("Test passed");
			$finish;
		end else begin
			abort_run($sformatf("Only %0d coordinate updates arrived", update_cnt));
		end
	end

	initial begin
		#(TIMEOUT_NS);
		abort_run("Watchdog expired before all frames completed");
	end

	always @(negedge cclk) begin : check_outputs
		touch_axis_e ax;
		logic [11:0] want_x, want_y, want_z;
		cycle_cnt <= cycle_cnt + 1;
		clk_q <= touch_clk;
		csb_q <= touch_csb;
		if (cycle_cnt < 16)
			assert (touch_csb) else report_mismatch("touch_csb", 1, touch_csb);
		// Idle outputs up to the first chip select
		if (!first_seen && touch_csb) begin
			assert (!touch_clk) else report_mismatch("touch_clk", 0, touch_clk);
			assert (!data_out) else report_mismatch("data_out", 0, data_out);
			assert (!xyz_update) else report_mismatch("xyz_update", 0, xyz_update);
			assert (x == 0 && y == 0 && z == 0) else report_mismatch("x|y|z", 0, x | y | z);
		end
		if (!touch_csb) begin
			first_seen <= 1'b1;
			if (touch_clk && !clk_q)
				rise_cnt <= rise_cnt + 1;
			if (csb_q && frame_idx > 0)
				assert (gap_cnt >= CLK_DIV)
					else report_mismatch("csb high cycles", CLK_DIV, gap_cnt);
		end else begin
			assert (!touch_clk) else report_mismatch("touch_clk", 0, touch_clk);
			gap_cnt <= gap_cnt + 1;
			if (!csb_q) begin
				assert (rise_cnt == FRAME_CLOCKS)
					else report_mismatch("touch_clk rises", FRAME_CLOCKS, rise_cnt);
				assert (cmd_seen == command_for(frame_idx))
					else report_mismatch("command", command_for(frame_idx), cmd_seen);
				frame_idx <= frame_idx + 1;
				rise_cnt <= 0;
				gap_cnt <= 1;
			end
		end
		// Only the register of the finished burst may move
		want_x = x_q;
		want_y = y_q;
		want_z = z_q;
		if (xyz_update) begin
			if (frame_idx == 0 || frame_idx % REPEATS != 0)
				abort_run("xyz_update outside the end of a burst");
			update_cnt <= update_cnt + 1;
			ax = axis_of_frame(frame_idx - 1);
			case (ax)
				AXIS_X:  want_x = exp_x;
				AXIS_Y:  want_y = exp_y;
				default: want_z = exp_z;
			endcase
		end
		assert (x == want_x) else report_mismatch("x", want_x, x);
		assert (y == want_y) else report_mismatch("y", want_y, y);
		assert (z == want_z) else report_mismatch("z", want_z, z);
		x_q <= x;
		y_q <= y;
		z_q <= z;
	end

endmodule

// ==== sim.f ====
touch_pkg.sv
touch_frame_if.sv
touch_clk_gen.sv
touch_spi_port.sv
touch_sequencer.sv
touch_calibrate.sv
touchpad_controller.sv
touch_adc_model.sv
tb_touchpad.sv
